/* rv_pipe.f */
+incdir+verilog
+incdir+bench
verilog/rv_pipe_pkg.sv
verilog/rv_pipe_buses.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_writeback.sv
verilog/rv_pipe_core.sv
bench/rv_pipe_tb.sv

/* bench/rv_pipe_program.svh */
/*
 * rv_pipe test program
 * Instruction table and the ordered list of stores it must produce
 */
`ifndef RV_PIPE_PROGRAM_SVH
`define RV_PIPE_PROGRAM_SVH

localparam int prog_len = 44;    // Words, NOPs beyond
localparam int n_stores = 18;

word_t       prog_rom [0:prog_len-1];
logic [63:0] store_tab [0:n_stores-1];   // {address, data}

task automatic load_tables();
	// Dependent chain, operands from EX, MEM and WB
	prog_rom[0]  = i_type(5, 0, 0, 1, `RV_OPC_OPIMM);       // addi x1,x0,5
	prog_rom[1]  = i_type(-3, 1, 0, 2, `RV_OPC_OPIMM);      // addi x2,x1,-3
	prog_rom[2]  = r_type(0, 2, 1, 0, 3);                   // add  x3,x1,x2
	prog_rom[3]  = r_type(32, 1, 3, 0, 4);                  // sub  x4,x3,x1
	prog_rom[4]  = s_type(0, 3, 0);                         // sw   x3,0(x0)
	prog_rom[5]  = s_type(4, 4, 0);                         // sw   x4,4(x0)
	// Logic ops on a LUI pattern
	prog_rom[6]  = u_type(20'hf0f0f, 5);                    // lui  x5,0xf0f0f
	prog_rom[7]  = i_type(255, 5, 6, 5, `RV_OPC_OPIMM);     // ori  x5,x5,0xff
	prog_rom[8]  = i_type(-1, 5, 4, 6, `RV_OPC_OPIMM);      // xori x6,x5,-1
	prog_rom[9]  = r_type(0, 6, 5, 7, 7);                   // and  x7,x5,x6
	prog_rom[10] = r_type(0, 6, 5, 6, 8);                   // or   x8,x5,x6
	prog_rom[11] = r_type(0, 8, 5, 4, 9);                   // xor  x9,x5,x8
	prog_rom[12] = i_type(12'h7f0, 5, 7, 10, `RV_OPC_OPIMM); // andi x10,x5,0x7f0
	prog_rom[13] = s_type(8, 5, 0);
	prog_rom[14] = s_type(12, 6, 0);
	prog_rom[15] = s_type(16, 7, 0);
	prog_rom[16] = s_type(20, 8, 0);
	prog_rom[17] = s_type(24, 9, 0);
	prog_rom[18] = s_type(28, 10, 0);
	// Shifts and compares
	prog_rom[19] = i_type(4, 0, 0, 11, `RV_OPC_OPIMM);      // addi x11,x0,4
	prog_rom[20] = r_type(0, 11, 5, 1, 12);                 // sll  x12,x5,x11
	prog_rom[21] = r_type(0, 11, 5, 5, 13);                 // srl  x13,x5,x11
	prog_rom[22] = r_type(32, 11, 5, 5, 14);                // sra  x14,x5,x11
	prog_rom[23] = r_type(0, 1, 5, 2, 15);                  // slt  x15,x5,x1
	prog_rom[24] = r_type(0, 1, 5, 3, 16);                  // sltu x16,x5,x1
	prog_rom[25] = i_type(6, 1, 2, 17, `RV_OPC_OPIMM);      // slti x17,x1,6
	prog_rom[26] = s_type(32, 12, 0);
	prog_rom[27] = s_type(36, 13, 0);
	prog_rom[28] = s_type(40, 14, 0);
	prog_rom[29] = s_type(44, 15, 0);
	prog_rom[30] = s_type(48, 16, 0);
	prog_rom[31] = s_type(52, 17, 0);
	// Load-use pair, then x0 write
	prog_rom[32] = i_type(64, 0, 2, 18, `RV_OPC_LOAD);      // lw   x18,64(x0)
	prog_rom[33] = r_type(0, 1, 18, 0, 19);                 // add  x19,x18,x1
	prog_rom[34] = s_type(56, 19, 0);
	prog_rom[35] = i_type(123, 0, 0, 0, `RV_OPC_OPIMM);     // addi x0,x0,123
	prog_rom[36] = s_type(60, 0, 0);                        // sw   x0,60(x0)
	// Control flow, poison stores at 68 and 76
	prog_rom[37] = b_type(8, 1, 1, 0);                      // beq  x1,x1,+8
	prog_rom[38] = s_type(68, 8, 0);
	prog_rom[39] = b_type(8, 1, 1, 1);                      // bne  x1,x1,+8
	prog_rom[40] = s_type(72, 1, 0);
	prog_rom[41] = j_type(8, 20);                           // jal  x20,+8
	prog_rom[42] = s_type(76, 8, 0);
	prog_rom[43] = s_type(80, 20, 0);                       // Link, 41*4+4

	store_tab[0]  = {32'd0,  32'd7};
	store_tab[1]  = {32'd4,  32'd2};
	store_tab[2]  = {32'd8,  32'hf0f0_f0ff};
	store_tab[3]  = {32'd12, 32'h0f0f_0f00};
	store_tab[4]  = {32'd16, 32'h0000_0000};
	store_tab[5]  = {32'd20, 32'hffff_ffff};
	store_tab[6]  = {32'd24, 32'h0f0f_0f00};
	store_tab[7]  = {32'd28, 32'h0000_00f0};
	store_tab[8]  = {32'd32, 32'h0f0f_0ff0};
	store_tab[9]  = {32'd36, 32'h0f0f_0f0f};
	store_tab[10] = {32'd40, 32'hff0f_0f0f};
	store_tab[11] = {32'd44, 32'd1};
	store_tab[12] = {32'd48, 32'd0};
	store_tab[13] = {32'd52, 32'd1};
	store_tab[14] = {32'd56, 32'hc0de_0045};   // Fill at 64 plus 5
	store_tab[15] = {32'd60, 32'd0};
	store_tab[16] = {32'd72, 32'd5};
	store_tab[17] = {32'd80, 32'd168};
endtask

`endif

/* bench/rv_pipe_tb.sv */
/*
 * rv_pipe testbench
 * Instruction and data memory models, store monitor with ordered checks
 */
`timescale 1ns/1ps

`include "rv_pipe_defs.svh"

module rv_pipe_tb import rv_pipe_pkg::*; ();

	localparam int dmem_words    = 64;
	localparam int store_timeout = 200;   // Cycles per expected store
	localparam int drain_cycles  = 50;

	logic  clk = 1'b0;
	logic  reset;
	word_t imem_addr;
	word_t imem_data;
	word_t dmem_addr;
	word_t dmem_wdata;
	logic  dmem_we;
	word_t dmem_rdata;

	word_t dmem [0:dmem_words-1];

	////////////////////////////////////////
	// Small assembler
	////////////////////////////////////////

	function automatic word_t r_type(int f7, int rs2, int rs1, int f3, int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `RV_OPC_OP};
	endfunction

	function automatic word_t i_type(int imm, int rs1, int f3, int rd, int opc);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
	endfunction

	function automatic word_t s_type(int imm, int rs2, int rs1);
		return {imm[11:5], rs2[4:0], rs1[4:0], `RV_F3_WORD, imm[4:0], `RV_OPC_STORE};
	endfunction

	function automatic word_t b_type(int imm, int rs2, int rs1, int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
			`RV_OPC_BRANCH};
	endfunction

	function automatic word_t j_type(int imm, int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `RV_OPC_JAL};
	endfunction

	function automatic word_t u_type(int imm, int rd);
		return {imm[19:0], rd[4:0], `RV_OPC_LUI};
	endfunction

	`include "rv_pipe_program.svh"

	always #20 clk = ~clk;          // 40 ns period

	rv_pipe_core i_dut (
		.clk(clk), .reset(reset),
		.imem_addr(imem_addr), .imem_data(imem_data),
		.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
		.dmem_we(dmem_we), .dmem_rdata(dmem_rdata)
	);

	// Instruction ROM with NOPs past the program
	assign imem_data = (imem_addr < prog_len * 4) ? prog_rom[imem_addr[31:2]] : `RV_NOP_WORD;

	// Data RAM with combinational read
	assign dmem_rdata = dmem[dmem_addr[7:2]];

	always @(posedge clk) begin
		if (dmem_we === 1'b1)
			dmem[dmem_addr[7:2]] <= dmem_wdata;
	end

	task automatic preload_dmem();
		for (int i = 0; i < dmem_words; i++)
			dmem[i] <= 32'hc0de_0000 + i * 4;   // Byte address in low half
	endtask

	task automatic fail_run();
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	////////////////////////////////////////
	// Store monitor
	////////////////////////////////////////

	task automatic expect_store(input int idx);
		int    waited;
		word_t want_addr;
		word_t want_data;
		want_addr = store_tab[idx][63:32];
		want_data = store_tab[idx][31:0];
		waited = 0;
		@(negedge clk);
		while (dmem_we !== 1'b1 && waited < store_timeout) begin
			@(negedge clk);
			waited++;
		end
		if (dmem_we !== 1'b1) begin
			$display("Store %0d to address %h never came within %0d cycles",
				idx, want_addr, store_timeout);
			fail_run();
		end else begin
			assert (dmem_addr === want_addr && dmem_wdata === want_data) else begin
				$display("ERR %0t: store %0d expected [%h]=%h, got [%h]=%h", $time,
					idx, want_addr, want_data, dmem_addr, dmem_wdata);
				fail_run();
			end
		end
	endtask

	// Nothing may store after the last expected one
	task automatic watch_drain();
		for (int c = 0; c < drain_cycles; c++) begin
			@(negedge clk);
			assert (dmem_we === 1'b0) else begin
				$display("ERR %0t: unexpected store [%h]=%h after the last one", $time,
					dmem_addr, dmem_wdata);
				fail_run();
			end
		end
	endtask

	initial begin
		reset = 1'b1;
		load_tables();
		preload_dmem();
		repeat (2) @(negedge clk);    // Two reset edges
		reset = 1'b0;
		assert (imem_addr === 32'd0 && dmem_we === 1'b0) else begin
			$display("ERR %0t: after reset imem_addr=%h dmem_we=%b", $time,
				imem_addr, dmem_we);
			fail_run();
		end
		for (int s = 0; s < n_stores; s++)
			expect_store(s);
		watch_drain();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* verilog/rv_pipe_core.sv */
/*
 * rv_pipe core top level
 * Five-stage RV32I subset, instruction and data memories outside
 */
`timescale 1ns/1ps

module rv_pipe_core import rv_pipe_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	// Instruction memory
	output word_t imem_addr,
	input  word_t imem_data,
	// Data memory
	output word_t dmem_addr,
	output word_t dmem_wdata,
	output logic  dmem_we,
	input  word_t dmem_rdata
);

	// Stage-to-stage controls
	logic  redirect;
	word_t redirect_pc;
	logic  stall;
	word_t if_pc;
	word_t if_inst;

	id_ex_bus  idx_bus ();
	ex_mem_bus exm_bus ();
	bypass_bus byp_bus ();

	fetch_stage i_fetch (
		.clk(clk), .reset(reset),
		.stall(stall), .redirect(redirect), .redirect_pc(redirect_pc),
		.imem_addr(imem_addr), .imem_data(imem_data),
		.if_pc(if_pc), .if_inst(if_inst)
	);

	decode_stage i_decode (
		.clk(clk), .reset(reset),
		.if_pc(if_pc), .if_inst(if_inst),
		.redirect(redirect), .stall(stall),
		.idx(idx_bus.decode), .byp(byp_bus.decode)
	);

	execute_stage i_execute (
		.clk(clk), .reset(reset),
		.idx(idx_bus.execute), .exm(exm_bus.execute), .byp(byp_bus.execute),
		.redirect(redirect), .redirect_pc(redirect_pc)
	);

	memory_writeback i_memwb (
		.clk(clk), .reset(reset),
		.exm(exm_bus.memory), .byp(byp_bus.memory),
		.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
		.dmem_we(dmem_we), .dmem_rdata(dmem_rdata)
	);

endmodule

/* verilog/memory_writeback.sv */
/*
 * Memory and writeback stages
 * Data-memory port, load/result select, MEM/WB register feeding the regfile
 */
`timescale 1ns/1ps

module memory_writeback import rv_pipe_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	ex_mem_bus.memory exm,
	bypass_bus.memory byp,
	output word_t dmem_addr,
	output word_t dmem_wdata,
	output logic  dmem_we,
	input  word_t dmem_rdata     // Combinational read
);

	word_t mem_data;

	// Data memory port
	assign dmem_addr  = exm.result;
	assign dmem_wdata = exm.store_data;
	assign dmem_we    = exm.is_store;   // Cleared on bubbles and reset

	// Load data or ALU/link result
	assign mem_data = exm.is_load ? dmem_rdata : exm.result;

	assign byp.mem_rd    = exm.rd;
	assign byp.mem_wr_en = exm.wr_en;
	assign byp.mem_data  = mem_data;

	////////////////////////////////////////
	// MEM/WB register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset)
			byp.wb_wr_en <= 1'b0;
		else
			byp.wb_wr_en <= exm.wr_en;
	end

	always_ff @(posedge clk) begin
		byp.wb_rd   <= exm.rd;
		byp.wb_data <= mem_data;      // Regfile write data
	end

endmodule

/* verilog/execute_stage.sv */
/*
 * Execute stage
 * ALU, BEQ/BNE compare, redirect to fetch, EX/MEM pipeline register
 */
`timescale 1ns/1ps

`include "rv_pipe_defs.svh"

module execute_stage import rv_pipe_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	id_ex_bus.execute  idx,
	ex_mem_bus.execute exm,
	bypass_bus.execute byp,
	output logic  redirect,      // One-cycle pulse, flush IF/ID and ID/EX
	output word_t redirect_pc
);

	word_t alu_out;
	word_t result;
	logic  taken;

	////////////////////////////////////////
	// ALU
	////////////////////////////////////////

	always_comb begin
		case (idx.alu_op)
			`RV_ALU_ADD:   alu_out = idx.opa + idx.opb;   // Also LW/SW address
			`RV_ALU_SUB:   alu_out = idx.opa - idx.opb;
			`RV_ALU_AND:   alu_out = idx.opa & idx.opb;
			`RV_ALU_OR:    alu_out = idx.opa | idx.opb;
			`RV_ALU_XOR:   alu_out = idx.opa ^ idx.opb;
			`RV_ALU_SLL:   alu_out = idx.opa << idx.opb[4:0];
			`RV_ALU_SRL:   alu_out = idx.opa >> idx.opb[4:0];
			`RV_ALU_SRA:   alu_out = word_t'($signed(idx.opa) >>> idx.opb[4:0]);
			`RV_ALU_SLT:   alu_out = {31'd0, $signed(idx.opa) < $signed(idx.opb)};
			`RV_ALU_SLTU:  alu_out = {31'd0, idx.opa < idx.opb};
			`RV_ALU_PASSB: alu_out = idx.opb;
			default:       alu_out = '0;
		endcase
	end

	// JAL links pc+4
	assign result = idx.is_jal ? idx.pc + 32'd4 : alu_out;

	// Branch resolve
	assign taken = (idx.is_beq && idx.opa == idx.opb) ||
		(idx.is_bne && idx.opa != idx.opb) || idx.is_jal;

	assign redirect    = taken;
	assign redirect_pc = idx.pc + idx.imm;

	// Forwarding taps, before EX/MEM
	assign byp.ex_rd      = idx.rd;
	assign byp.ex_wr_en   = idx.wr_en;
	assign byp.ex_is_load = idx.is_load;
	assign byp.ex_result  = result;

	////////////////////////////////////////
	// EX/MEM register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			exm.wr_en    <= 1'b0;
			exm.is_load  <= 1'b0;
			exm.is_store <= 1'b0;
		end else begin
			exm.wr_en    <= idx.wr_en;
			exm.is_load  <= idx.is_load;
			exm.is_store <= idx.is_store;
		end
	end

	always_ff @(posedge clk) begin
		exm.result     <= result;
		exm.store_data <= idx.store_data;
		exm.rd         <= idx.rd;
	end

endmodule

/* verilog/decode_stage.sv */
/*
 * Decode stage
 * Decoder, immediate build, register file, forwarding muxes,
 * load-use detect and the ID/EX pipeline register
 */
`timescale 1ns/1ps

`include "rv_pipe_defs.svh"

module decode_stage import rv_pipe_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  word_t if_pc,
	input  word_t if_inst,
	input  logic  redirect,      // Bubble the ID/EX register
	output logic  stall,         // Load-use hold to fetch
	id_ex_bus.decode  idx,
	bypass_bus.decode byp
);

	// Instruction fields
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       funct7_alt;      // inst[30], SUB/SRA select
	reg_addr_t  rd;
	reg_addr_t  rs1;
	reg_addr_t  rs2;

	assign opcode     = if_inst[6:0];
	assign rd         = if_inst[11:7];
	assign funct3     = if_inst[14:12];
	assign rs1        = if_inst[19:15];
	assign rs2        = if_inst[24:20];
	assign funct7_alt = if_inst[30];

	// Immediates, sign-extended
	word_t imm_i, imm_s, imm_b, imm_j, imm_u;

	assign imm_i = {{20{if_inst[31]}}, if_inst[31:20]};
	assign imm_s = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
	assign imm_b = {{19{if_inst[31]}}, if_inst[31], if_inst[7], if_inst[30:25],
		if_inst[11:8], 1'b0};
	assign imm_j = {{11{if_inst[31]}}, if_inst[31], if_inst[19:12], if_inst[20],
		if_inst[30:21], 1'b0};
	assign imm_u = {if_inst[31:12], 12'd0};

	////////////////////////////////////////
	// Control decode
	////////////////////////////////////////

	alu_op_t dec_alu_op;
	word_t   dec_imm;
	logic    dec_wr_en, dec_is_load, dec_is_store;
	logic    dec_is_beq, dec_is_bne, dec_is_jal;
	logic    use_imm;            // opb takes the immediate
	logic    use_rs1, use_rs2;   // Sources that can hit a load

	always_comb begin
		dec_alu_op   = `RV_ALU_ADD;
		dec_imm      = imm_i;
		dec_wr_en    = 1'b0;
		dec_is_load  = 1'b0;
		dec_is_store = 1'b0;
		dec_is_beq   = 1'b0;
		dec_is_bne   = 1'b0;
		dec_is_jal   = 1'b0;
		use_imm      = 1'b0;
		use_rs1      = 1'b0;
		use_rs2      = 1'b0;
		case (opcode)
			`RV_OPC_OP: begin
				dec_wr_en = 1'b1;
				use_rs1   = 1'b1;
				use_rs2   = 1'b1;
				case (funct3)
					`RV_F3_ADD:  dec_alu_op = funct7_alt ? `RV_ALU_SUB : `RV_ALU_ADD;
					`RV_F3_SLL:  dec_alu_op = `RV_ALU_SLL;
					`RV_F3_SLT:  dec_alu_op = `RV_ALU_SLT;
					`RV_F3_SLTU: dec_alu_op = `RV_ALU_SLTU;
					`RV_F3_XOR:  dec_alu_op = `RV_ALU_XOR;
					`RV_F3_SR:   dec_alu_op = funct7_alt ? `RV_ALU_SRA : `RV_ALU_SRL;
					`RV_F3_OR:   dec_alu_op = `RV_ALU_OR;
					default:     dec_alu_op = `RV_ALU_AND;
				endcase
			end
			`RV_OPC_OPIMM: begin
				use_imm = 1'b1;
				use_rs1 = 1'b1;
				dec_wr_en = 1'b1;
				case (funct3)
					`RV_F3_ADD: dec_alu_op = `RV_ALU_ADD;
					`RV_F3_SLT: dec_alu_op = `RV_ALU_SLT;
					`RV_F3_XOR: dec_alu_op = `RV_ALU_XOR;
					`RV_F3_OR:  dec_alu_op = `RV_ALU_OR;
					`RV_F3_AND: dec_alu_op = `RV_ALU_AND;
					default:    dec_wr_en  = 1'b0;   // Unsupported, retire as no-op
				endcase
			end
			`RV_OPC_LUI: begin
				dec_alu_op = `RV_ALU_PASSB;
				dec_imm    = imm_u;
				use_imm    = 1'b1;
				dec_wr_en  = 1'b1;
			end
			`RV_OPC_LOAD: begin
				use_imm     = 1'b1;
				use_rs1     = 1'b1;
				dec_is_load = (funct3 == `RV_F3_WORD);
				dec_wr_en   = (funct3 == `RV_F3_WORD);
			end
			`RV_OPC_STORE: begin
				dec_imm      = imm_s;
				use_imm      = 1'b1;
				use_rs1      = 1'b1;
				use_rs2      = 1'b1;
				dec_is_store = (funct3 == `RV_F3_WORD);
			end
			`RV_OPC_BRANCH: begin
				dec_imm    = imm_b;
				use_rs1    = 1'b1;
				use_rs2    = 1'b1;
				dec_is_beq = (funct3 == `RV_F3_BEQ);
				dec_is_bne = (funct3 == `RV_F3_BNE);
			end
			`RV_OPC_JAL: begin
				dec_imm    = imm_j;
				dec_wr_en  = 1'b1;       // Link, pc+4 made in execute
				dec_is_jal = 1'b1;
			end
			default: ;                   // Anything else is a no-op
		endcase
	end

	////////////////////////////////////////
	// Register file, x0 reads zero
	////////////////////////////////////////

	word_t regs [0:(1 << `RV_REG_BITS)-1];
	word_t rf_a, rf_b;

	always_ff @(posedge clk) begin
		if (byp.wb_wr_en && byp.wb_rd != '0)
			regs[byp.wb_rd] <= byp.wb_data;
	end

	assign rf_a = (rs1 == '0) ? '0 : regs[rs1];
	assign rf_b = (rs2 == '0) ? '0 : regs[rs2];

	// Youngest producer first, EX then MEM then WB
	function automatic word_t bypass_sel(input reg_addr_t rs, input word_t rf_val);
		word_t sel;
		sel = rf_val;
		if (rs != '0) begin
			if (byp.ex_wr_en && !byp.ex_is_load && byp.ex_rd == rs)
				sel = byp.ex_result;
			else if (byp.mem_wr_en && byp.mem_rd == rs)
				sel = byp.mem_data;
			else if (byp.wb_wr_en && byp.wb_rd == rs)
				sel = byp.wb_data;
		end
		return sel;
	endfunction

	word_t fwd_a, fwd_b;

	always_comb begin
		fwd_a = bypass_sel(rs1, rf_a);
		fwd_b = bypass_sel(rs2, rf_b);
	end

	// Load in execute feeding a source here
	assign stall = byp.ex_is_load && byp.ex_rd != '0 &&
		((use_rs1 && rs1 == byp.ex_rd) || (use_rs2 && rs2 == byp.ex_rd));

	////////////////////////////////////////
	// ID/EX register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset || stall || redirect) begin
			idx.wr_en    <= 1'b0;    // Bubble
			idx.is_load  <= 1'b0;
			idx.is_store <= 1'b0;
			idx.is_beq   <= 1'b0;
			idx.is_bne   <= 1'b0;
			idx.is_jal   <= 1'b0;
		end else begin
			idx.wr_en    <= dec_wr_en;
			idx.is_load  <= dec_is_load;
			idx.is_store <= dec_is_store;
			idx.is_beq   <= dec_is_beq;
			idx.is_bne   <= dec_is_bne;
			idx.is_jal   <= dec_is_jal;
		end
	end

	always_ff @(posedge clk) begin
		idx.pc         <= if_pc;
		idx.opa        <= fwd_a;
		idx.opb        <= use_imm ? dec_imm : fwd_b;
		idx.store_data <= fwd_b;
		idx.imm        <= dec_imm;
		idx.rd         <= rd;
		idx.alu_op     <= dec_alu_op;
	end

endmodule

/* verilog/fetch_stage.sv */
/*
 * Fetch stage
 * PC register, next-PC select and the IF/ID pipeline register
 */
`timescale 1ns/1ps

`include "rv_pipe_defs.svh"

module fetch_stage import rv_pipe_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  stall,         // Load-use hold from decode
	input  logic  redirect,      // Taken branch or JAL in execute
	input  word_t redirect_pc,
	output word_t imem_addr,
	input  word_t imem_data,
	output word_t if_pc,         // IF/ID outputs
	output word_t if_inst
);

	word_t pc;
	word_t pc_next;

	assign imem_addr = pc;

	// Redirect wins over stall
	always_comb begin
		if (redirect)
			pc_next = redirect_pc;
		else if (stall)
			pc_next = pc;          // Hold
		else
			pc_next = pc + 32'd4;
	end

	always_ff @(posedge clk) begin
		if (reset)
			pc <= '0;
		else
			pc <= pc_next;
	end

	////////////////////////////////////////
	// IF/ID register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset)
			if_inst <= `RV_NOP_WORD;
		else if (redirect)
			if_inst <= `RV_NOP_WORD; // Kill the wrong-path fetch
		else if (!stall)
			if_inst <= imem_data;
	end

	always_ff @(posedge clk) begin
		if (redirect || !stall)
			if_pc <= pc;
	end

endmodule

/* verilog/rv_pipe_buses.sv */
/*
 * rv_pipe inter-stage buses
 * ID/EX and EX/MEM register outputs, plus the forwarding bus into decode
 */
`timescale 1ns/1ps

// ID/EX register outputs
interface id_ex_bus import rv_pipe_pkg::*; ();
	word_t     pc;           // PC of instruction in execute
	word_t     opa;          // Forwarded rs1
	word_t     opb;          // Forwarded rs2 or immediate
	word_t     store_data;   // Forwarded rs2 for SW
	word_t     imm;          // Branch/jump offset
	reg_addr_t rd;
	alu_op_t   alu_op;
	logic      wr_en;
	logic      is_load;
	logic      is_store;
	logic      is_beq;
	logic      is_bne;
	logic      is_jal;

	modport decode (output pc, opa, opb, store_data, imm, rd, alu_op,
		wr_en, is_load, is_store, is_beq, is_bne, is_jal);
	modport execute (input pc, opa, opb, store_data, imm, rd, alu_op,
		wr_en, is_load, is_store, is_beq, is_bne, is_jal);
endinterface

// EX/MEM register outputs
interface ex_mem_bus import rv_pipe_pkg::*; ();
	word_t     result;       // ALU result, address, or pc+4 for JAL
	word_t     store_data;
	reg_addr_t rd;
	logic      wr_en;
	logic      is_load;
	logic      is_store;

	modport execute (output result, store_data, rd, wr_en, is_load, is_store);
	modport memory (input result, store_data, rd, wr_en, is_load, is_store);
endinterface

// Forwarding sources seen by decode
interface bypass_bus import rv_pipe_pkg::*; ();
	// Execute, before EX/MEM
	reg_addr_t ex_rd;
	logic      ex_wr_en;
	logic      ex_is_load;   // Result not ready, load-use stall
	word_t     ex_result;
	// Memory, load data or result
	reg_addr_t mem_rd;
	logic      mem_wr_en;
	word_t     mem_data;
	// Writeback, also the regfile write port
	reg_addr_t wb_rd;
	logic      wb_wr_en;
	word_t     wb_data;

	modport execute (output ex_rd, ex_wr_en, ex_is_load, ex_result);
	modport memory (output mem_rd, mem_wr_en, mem_data, wb_rd, wb_wr_en, wb_data);
	modport decode (input ex_rd, ex_wr_en, ex_is_load, ex_result,
		mem_rd, mem_wr_en, mem_data, wb_rd, wb_wr_en, wb_data);
endinterface

/* verilog/rv_pipe_pkg.sv */
/*
 * rv_pipe package
 * Vector types shared by all pipeline stages and buses
 */
`include "rv_pipe_defs.svh"

package rv_pipe_pkg;

	////////////////////////////////////////
	// Datapath types
	////////////////////////////////////////

	// Data word, PC or instruction
	typedef logic [`RV_XLEN-1:0] word_t;

	// Register number, x0..x31
	typedef logic [`RV_REG_BITS-1:0] reg_addr_t;

	// ALU op code, see RV_ALU_* codes
	typedef logic [`RV_ALU_OP_BITS-1:0] alu_op_t;

endpackage

/* verilog/rv_pipe_defs.svh */
/*
 * rv_pipe shared constants
 * Widths, RV32I major opcodes, funct3 codes, ALU op codes, NOP word
 */
`ifndef RV_PIPE_DEFS_SVH
`define RV_PIPE_DEFS_SVH

`define RV_XLEN         32      // Data word width
`define RV_REG_BITS     5       // Register address width
`define RV_ALU_OP_BITS  4       // ALU op code width

// Major opcodes, inst[6:0]
`define RV_OPC_OP       7'b0110011
`define RV_OPC_OPIMM    7'b0010011
`define RV_OPC_LUI      7'b0110111
`define RV_OPC_LOAD     7'b0000011
`define RV_OPC_STORE    7'b0100011
`define RV_OPC_BRANCH   7'b1100011
`define RV_OPC_JAL      7'b1101111

// funct3 codes
`define RV_F3_ADD       3'b000  // ADD/SUB/ADDI
`define RV_F3_SLL       3'b001
`define RV_F3_SLT       3'b010
`define RV_F3_SLTU      3'b011
`define RV_F3_XOR       3'b100
`define RV_F3_SR        3'b101  // SRL/SRA
`define RV_F3_OR        3'b110
`define RV_F3_AND       3'b111
`define RV_F3_BEQ       3'b000
`define RV_F3_BNE       3'b001
`define RV_F3_WORD      3'b010  // LW/SW only

// ALU op codes
`define RV_ALU_ADD      4'd0
`define RV_ALU_SUB      4'd1
`define RV_ALU_AND      4'd2
`define RV_ALU_OR       4'd3
`define RV_ALU_XOR      4'd4
`define RV_ALU_SLL      4'd5
`define RV_ALU_SRL      4'd6
`define RV_ALU_SRA      4'd7
`define RV_ALU_SLT      4'd8
`define RV_ALU_SLTU     4'd9
`define RV_ALU_PASSB    4'd10   // LUI, operand B straight through

`define RV_NOP_WORD     32'h0000_0013   // ADDI x0,x0,0

`endif
